// File: fix_proto_pkg.sv
////////////////////
// FIX protocol constants.
// Byte codes of the delimiters, the absent-position code and the digit range.
////////////////////

package fix_proto_pkg;

	// Field terminator.
	localparam logic [7:0] SOH_BYTE = 8'h01;

	// Tag/value separator, the ASCII '='.
	localparam logic [7:0] SEP_BYTE = 8'h3d;

	localparam logic [2:0] POS_NONE = 3'b111; // No delimiter in the word.

	// ASCII '0' and '9'.
	localparam logic [7:0] DIGIT_LO = 8'h30;
	localparam logic [7:0] DIGIT_HI = 8'h39;

endpackage

// File: fix_field_pkg.sv
////////////////////
// FIX datapath types.
// Widths of words, byte positions, fragments, tag numbers and lengths.
////////////////////

package fix_field_pkg;

	// One input word, earliest byte in bits 31:24.
	typedef logic [31:0] word_t;

	// Byte index from the least significant byte, so 3 is the earliest byte.
	typedef logic [2:0] pos_t;

	// Right-aligned fragment of up to four bytes.
	typedef logic [31:0] frag_t;

	typedef logic [2:0] frag_len_t; // 0 to 4 bytes.

	// Binary tag number, wide enough for five decimal digits.
	typedef logic [16:0] tag_num_t;

	typedef logic [4:0] val_len_t;

endpackage

// File: fix_delim_decode.sv
////////////////////
// FIX delimiter decode.
// Registers each word with the byte positions of SOH and '='.
////////////////////

`timescale 1ns/1ns

module fix_delim_decode (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 word_valid_i,
	input  fix_field_pkg::word_t word_i,
	output logic                 dec_valid_o,
	output fix_field_pkg::word_t dec_word_o,
	output fix_field_pkg::pos_t  soh_pos_o,
	output fix_field_pkg::pos_t  sep_pos_o
);

	fix_field_pkg::pos_t soh_hit;
	fix_field_pkg::pos_t sep_hit;

	// Later iterations win, so the earliest matching byte is reported.
	always_comb begin
		soh_hit = fix_proto_pkg::POS_NONE;
		sep_hit = fix_proto_pkg::POS_NONE;
		for (int i = 0; i < 4; i++) begin
			if (word_i[8*i +: 8] == fix_proto_pkg::SOH_BYTE) begin
				soh_hit = fix_field_pkg::pos_t'(i);
			end
			if (word_i[8*i +: 8] == fix_proto_pkg::SEP_BYTE) begin
				sep_hit = fix_field_pkg::pos_t'(i);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= word_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (word_valid_i) begin
			dec_word_o <= word_i;
			soh_pos_o <= soh_hit;
			sep_pos_o <= sep_hit;
		end
	end

	// A reported position lies inside the word and points at its delimiter.
	a_pos_range: assert property (@(posedge clk_i) disable iff (reset_i)
		dec_valid_o |-> (soh_pos_o == fix_proto_pkg::POS_NONE ||
			(soh_pos_o < 3'd4 && dec_word_o[8*soh_pos_o +: 8] == fix_proto_pkg::SOH_BYTE)) &&
			(sep_pos_o == fix_proto_pkg::POS_NONE ||
			(sep_pos_o < 3'd4 && dec_word_o[8*sep_pos_o +: 8] == fix_proto_pkg::SEP_BYTE)))
		else $error("decode produced a delimiter position outside the word");

endmodule

// File: fix_field_split.sv
////////////////////
// FIX field split.
// Cuts each word into a tag fragment and a value fragment and tracks
// whether the stream is inside a tag or inside a value.
////////////////////

`timescale 1ns/1ns

module fix_field_split (
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic                     dec_valid_i,
	input  fix_field_pkg::word_t     dec_word_i,
	input  fix_field_pkg::pos_t      soh_pos_i,
	input  fix_field_pkg::pos_t      sep_pos_i,
	output logic                     frag_valid_o,
	output fix_field_pkg::frag_t     tag_frag_o,
	output fix_field_pkg::frag_len_t tag_len_o,
	output fix_field_pkg::frag_t     val_frag_o,
	output fix_field_pkg::frag_len_t val_len_o,
	output logic                     field_end_o,
	output logic                     tag_after_end_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_IN_TAG, ST_IN_VAL} split_state_t;

	split_state_t state, state_nxt;
	fix_field_pkg::pos_t d1, d2;
	fix_field_pkg::frag_len_t lead_len, mid_len;
	fix_field_pkg::frag_t lead, mid, tail;
	fix_field_pkg::frag_t tag_f, val_f, val_out;
	fix_field_pkg::frag_len_t tag_l, val_l, val_len_out;
	logic field_end, tag_after_end;
	logic pend_vld, carry_vld, carry_vld_nxt;
	logic [7:0] carry_byte, carry_nxt;

	// Bytes lo+len-1 down to lo of the word, right-aligned.
	function automatic fix_field_pkg::frag_t seg(input fix_field_pkg::word_t w,
			input fix_field_pkg::pos_t lo, input fix_field_pkg::frag_len_t len);
		fix_field_pkg::frag_t mask;
		mask = (len > 3'd3) ? '1 : ((32'd1 << (len * 8)) - 32'd1);
		return (w >> (lo * 8)) & mask;
	endfunction

	always_comb begin
		d1 = (soh_pos_i != fix_proto_pkg::POS_NONE) ? soh_pos_i : sep_pos_i; // Earlier delimiter.
		d2 = d1;
		if (soh_pos_i != fix_proto_pkg::POS_NONE && sep_pos_i != fix_proto_pkg::POS_NONE) begin
			d1 = (soh_pos_i > sep_pos_i) ? soh_pos_i : sep_pos_i;
			d2 = (soh_pos_i > sep_pos_i) ? sep_pos_i : soh_pos_i;
		end
		lead_len = 3'd3 - d1;
		mid_len = d1 - d2 - 3'd1;
		lead = seg(dec_word_i, d1 + 3'd1, lead_len);
		mid = seg(dec_word_i, d2 + 3'd1, mid_len);
		tail = seg(dec_word_i, 3'd0, d2);
		tag_f = '0;
		tag_l = '0;
		val_f = '0;
		val_l = '0;
		field_end = 1'b0;
		tag_after_end = 1'b0;
		pend_vld = 1'b0;
		state_nxt = state;
		if (soh_pos_i == fix_proto_pkg::POS_NONE && sep_pos_i == fix_proto_pkg::POS_NONE) begin
			if (state == ST_IN_VAL) begin
				val_f = dec_word_i;
				val_l = 3'd4;
			end else begin
				tag_f = dec_word_i;
				tag_l = 3'd4;
				state_nxt = ST_IN_TAG;
			end
		end else if (soh_pos_i == fix_proto_pkg::POS_NONE) begin
			tag_f = lead;
			tag_l = lead_len;
			val_f = tail;
			val_l = d2;
			state_nxt = ST_IN_VAL;
		end else if (sep_pos_i == fix_proto_pkg::POS_NONE) begin
			val_f = lead;
			val_l = lead_len;
			tag_f = tail;
			tag_l = d2;
			field_end = 1'b1;
			tag_after_end = (d2 != 3'd0);
			state_nxt = (d2 != 3'd0) ? ST_IN_TAG : ST_IDLE;
		end else if (sep_pos_i > soh_pos_i) begin
			// A leading tag and a new tag cannot share the fragment. The leading one wins.
			val_f = mid;
			val_l = mid_len;
			field_end = 1'b1;
			tag_f = (lead_len != 3'd0) ? lead : tail;
			tag_l = (lead_len != 3'd0) ? lead_len : d2;
			tag_after_end = (lead_len == 3'd0) && (d2 != 3'd0);
			state_nxt = (d2 != 3'd0) ? ST_IN_TAG : ST_IDLE;
		end else begin
			val_f = lead;
			val_l = lead_len;
			tag_f = mid;
			tag_l = mid_len;
			field_end = 1'b1;
			tag_after_end = (mid_len != 3'd0);
			pend_vld = (d2 == 3'd1); // New value byte waits for the next fragment.
			state_nxt = ST_IN_VAL;
		end
	end

	// A held value byte is put in front of the next value fragment.
	always_comb begin
		val_out = val_f;
		val_len_out = val_l;
		carry_nxt = dec_word_i[7:0];
		carry_vld_nxt = pend_vld;
		if (carry_vld) begin
			if (val_l == 3'd4) begin
				val_out = {carry_byte, val_f[31:8]};
				carry_vld_nxt = 1'b1;
			end else begin
				val_out = ({24'd0, carry_byte} << (val_l * 8)) | val_f;
				val_len_out = val_l + 3'd1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= ST_IDLE;
			carry_vld <= 1'b0;
			frag_valid_o <= 1'b0;
		end else begin
			frag_valid_o <= dec_valid_i;
			if (dec_valid_i) begin
				state <= state_nxt;
				carry_vld <= carry_vld_nxt;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (dec_valid_i) begin
			tag_frag_o <= tag_f;
			tag_len_o <= tag_l;
			val_frag_o <= val_out;
			val_len_o <= val_len_out;
			field_end_o <= field_end;
			tag_after_end_o <= tag_after_end;
			carry_byte <= carry_nxt;
		end
	end

	a_sep_in_value: assert property (@(posedge clk_i) disable iff (reset_i)
		dec_valid_i && sep_pos_i != fix_proto_pkg::POS_NONE && state == ST_IN_VAL
		|-> soh_pos_i != fix_proto_pkg::POS_NONE && soh_pos_i > sep_pos_i)
		else $error("'=' inside a value without a preceding SOH");

endmodule

// File: fix_field_assemble.sv
////////////////////
// FIX field assemble.
// Joins fragments into whole fields, converts the tag digits to binary
// and pulses once per finished field.
////////////////////

`timescale 1ns/1ns

module fix_field_assemble #(
	parameter int VALUE_BYTES = 8,
	parameter int TAG_DIGITS = 5
) (
	input  logic                       clk_i,
	input  logic                       reset_i,
	input  logic                       frag_valid_i,
	input  fix_field_pkg::frag_t       tag_frag_i,
	input  fix_field_pkg::frag_len_t   tag_len_i,
	input  fix_field_pkg::frag_t       val_frag_i,
	input  fix_field_pkg::frag_len_t   val_len_i,
	input  logic                       field_end_i,
	input  logic                       tag_after_end_i,
	output logic                       field_valid_o,
	output fix_field_pkg::tag_num_t    tag_o,
	output logic [VALUE_BYTES*8-1:0]   value_o,
	output fix_field_pkg::val_len_t    value_len_o,
	output logic                       overflow_o
);

	fix_field_pkg::tag_num_t tag_acc, tag_cur, tag_new;
	logic [4:0] tag_cnt, tag_cnt_cur, tag_cnt_new; // Digits seen so far.
	logic [VALUE_BYTES*8-1:0] val_acc, val_cur;
	fix_field_pkg::val_len_t val_cnt, val_cnt_cur;
	logic ovf_acc, ovf_cur;
	logic [7:0] ch;

	function automatic fix_field_pkg::tag_num_t tag_step(input fix_field_pkg::tag_num_t acc,
			input logic [7:0] c);
		logic [7:0] d;
		d = c - fix_proto_pkg::DIGIT_LO;
		return fix_field_pkg::tag_num_t'(acc * 17'd10 + {9'd0, d});
	endfunction

	always_comb begin
		tag_cur = tag_acc;
		tag_cnt_cur = tag_cnt;
		tag_new = '0;
		tag_cnt_new = '0;
		val_cur = val_acc;
		val_cnt_cur = val_cnt;
		ovf_cur = ovf_acc;
		ch = '0;
		for (int i = 0; i < 4; i++) begin
			if (i < tag_len_i) begin
				ch = tag_frag_i[8*(tag_len_i-1-i) +: 8]; // Earliest byte first.
				if (ch >= fix_proto_pkg::DIGIT_LO && ch <= fix_proto_pkg::DIGIT_HI) begin
					if (tag_after_end_i) begin
						tag_new = tag_step(tag_new, ch);
						tag_cnt_new = tag_cnt_new + 5'd1;
					end else begin
						tag_cur = tag_step(tag_cur, ch);
						tag_cnt_cur = tag_cnt_cur + 5'd1;
					end
				end
			end
		end
		for (int i = 0; i < 4; i++) begin
			if (i < val_len_i) begin
				ch = val_frag_i[8*(val_len_i-1-i) +: 8];
				if (val_cnt_cur < VALUE_BYTES) begin
					val_cur[8*(VALUE_BYTES-1-val_cnt_cur) +: 8] = ch;
					val_cnt_cur = val_cnt_cur + 5'd1;
				end else begin
					ovf_cur = 1'b1; // Bytes past VALUE_BYTES are dropped.
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			tag_acc <= '0;
			tag_cnt <= '0;
			val_acc <= '0;
			val_cnt <= '0;
			ovf_acc <= 1'b0;
			field_valid_o <= 1'b0;
			overflow_o <= 1'b0;
		end else begin
			field_valid_o <= frag_valid_i && field_end_i;
			if (frag_valid_i && field_end_i) begin
				overflow_o <= ovf_cur;
				tag_acc <= tag_new; // Seeded by a tag that follows the SOH.
				tag_cnt <= tag_cnt_new;
				val_acc <= '0;
				val_cnt <= '0;
				ovf_acc <= 1'b0;
			end else if (frag_valid_i) begin
				tag_acc <= tag_cur;
				tag_cnt <= tag_cnt_cur;
				val_acc <= val_cur;
				val_cnt <= val_cnt_cur;
				ovf_acc <= ovf_cur;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (frag_valid_i && field_end_i) begin
			tag_o <= tag_cur;
			value_o <= val_cur;
			value_len_o <= val_cnt_cur;
		end
	end

	a_tag_digits: assert property (@(posedge clk_i) disable iff (reset_i)
		tag_cnt <= TAG_DIGITS)
		else $error("tag longer than %0d digits", TAG_DIGITS);

endmodule

// File: fix_parser_top.sv
////////////////////
// FIX parser top.
// Decode, split and assemble stages in a three-cycle pipeline.
////////////////////

`timescale 1ns/1ns

module fix_parser_top #(
	parameter int VALUE_BYTES = 8,
	parameter int TAG_DIGITS = 5
) (
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic                     word_valid_i,
	input  fix_field_pkg::word_t     word_i,
	output logic                     field_valid_o,
	output fix_field_pkg::tag_num_t  tag_o,
	output logic [VALUE_BYTES*8-1:0] value_o,
	output fix_field_pkg::val_len_t  value_len_o,
	output logic                     overflow_o
);

	logic dec_valid;
	fix_field_pkg::word_t dec_word;
	fix_field_pkg::pos_t soh_pos, sep_pos;
	logic frag_valid;
	fix_field_pkg::frag_t tag_frag, val_frag;
	fix_field_pkg::frag_len_t tag_len, val_len;
	logic field_end, tag_after_end;

	fix_delim_decode u_decode (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.word_valid_i (word_valid_i),
		.word_i       (word_i),
		.dec_valid_o  (dec_valid),
		.dec_word_o   (dec_word),
		.soh_pos_o    (soh_pos),
		.sep_pos_o    (sep_pos)
	);

	fix_field_split u_split (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.dec_valid_i     (dec_valid),
		.dec_word_i      (dec_word),
		.soh_pos_i       (soh_pos),
		.sep_pos_i       (sep_pos),
		.frag_valid_o    (frag_valid),
		.tag_frag_o      (tag_frag),
		.tag_len_o       (tag_len),
		.val_frag_o      (val_frag),
		.val_len_o       (val_len),
		.field_end_o     (field_end),
		.tag_after_end_o (tag_after_end)
	);

	fix_field_assemble #(
		.VALUE_BYTES (VALUE_BYTES),
		.TAG_DIGITS  (TAG_DIGITS)
	) u_assemble (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.frag_valid_i    (frag_valid),
		.tag_frag_i      (tag_frag),
		.tag_len_i       (tag_len),
		.val_frag_i      (val_frag),
		.val_len_i       (val_len),
		.field_end_i     (field_end),
		.tag_after_end_i (tag_after_end),
		.field_valid_o   (field_valid_o),
		.tag_o           (tag_o),
		.value_o         (value_o),
		.value_len_o     (value_len_o),
		.overflow_o      (overflow_o)
	);

endmodule

// File: tb_fix_parser.sv
////////////////////
// FIX parser testbench.
// Streams FIX fields through the parser and checks every field it emits.
////////////////////

`timescale 1ns/1ns

module tb_fix_parser;

	localparam int VALUE_BYTES = 8;
	localparam int CLK_HALF = 10;
	localparam int WD_MARGIN = 1000; // Cycles for resets and drains.

	logic                     clk_i;
	logic                     reset_i;
	logic                     word_valid_i;
	fix_field_pkg::word_t     word_i;
	logic                     field_valid_o;
	fix_field_pkg::tag_num_t  tag_o;
	logic [VALUE_BYTES*8-1:0] value_o;
	fix_field_pkg::val_len_t  value_len_o;
	logic                     overflow_o;

	// Expected fields in arrival order, the oldest at rd_ptr.
	fix_field_pkg::tag_num_t exp_tag [0:255];
	logic [VALUE_BYTES*8-1:0] exp_val [0:255];
	fix_field_pkg::val_len_t exp_len [0:255];
	logic exp_ovf [0:255];
	int wr_ptr = 0;
	int rd_ptr = 0;

	logic [7:0] byte_q [$];
	integer seed = 32'h97cc4092;
	int err_cnt = 0;
	int case_err0 = 0;
	int case_cnt = 0;
	int case_fail = 0;
	string case_name;
	int wd_cycles = 0;
	int wd_limit = WD_MARGIN;

	fix_parser_top #(
		.VALUE_BYTES (VALUE_BYTES),
		.TAG_DIGITS  (5)
	) u_dut (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.word_valid_i (word_valid_i),
		.word_i       (word_i),
		.field_valid_o(field_valid_o),
		.tag_o        (tag_o),
		.value_o      (value_o),
		.value_len_o  (value_len_o),
		.overflow_o   (overflow_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #CLK_HALF clk_i = ~clk_i;
	end

	function automatic logic has_soh(input fix_field_pkg::word_t w);
		for (int i = 0; i < 4; i++) begin
			if (w[8*i +: 8] == fix_proto_pkg::SOH_BYTE) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	always @(posedge clk_i) begin
		if (!reset_i && field_valid_o && rd_ptr != wr_ptr) begin
			rd_ptr <= rd_ptr + 1;
		end
	end

	a_field_match: assert property (@(posedge clk_i) disable iff (reset_i)
		field_valid_o && rd_ptr != wr_ptr |-> tag_o == exp_tag[rd_ptr] &&
			value_o == exp_val[rd_ptr] && value_len_o == exp_len[rd_ptr] &&
			overflow_o == exp_ovf[rd_ptr])
		else begin
			err_cnt++;
			$display("[ERROR] %0t ns: got tag %0d value %h len %0d ovf %b, expected %0d %h %0d %b",
				$time, $sampled(tag_o), $sampled(value_o), $sampled(value_len_o),
				$sampled(overflow_o), exp_tag[$sampled(rd_ptr)], exp_val[$sampled(rd_ptr)],
				exp_len[$sampled(rd_ptr)], exp_ovf[$sampled(rd_ptr)]);
		end

	a_field_expected: assert property (@(posedge clk_i) disable iff (reset_i)
		field_valid_o |-> rd_ptr != wr_ptr)
		else begin
			err_cnt++;
			$display("[ERROR] %0t ns: field_valid_o pulsed with no field expected", $time);
		end

	// A word that ends a field gives its pulse exactly three cycles later.
	a_field_latency: assert property (@(posedge clk_i) disable iff (reset_i)
		word_valid_i && has_soh(word_i) |-> ##3 field_valid_o)
		else begin
			err_cnt++;
			$display("[ERROR] %0t ns: no field pulse 3 cycles after a word with SOH", $time);
		end

	// Three pipeline stages mean no field can appear within 3 cycles of reset.
	a_quiet_reset: assert property (@(posedge clk_i)
		reset_i |=> !field_valid_o ##1 !field_valid_o ##1 !field_valid_o)
		else begin
			err_cnt++;
			$display("[ERROR] %0t ns: field_valid_o high during or right after reset", $time);
		end

	task automatic push_raw(input string s);
		for (int i = 0; i < s.len(); i++) begin
			byte_q.push_back(s[i]);
		end
	endtask

	// Appends tag=value SOH and records what the parser has to report for it.
	task automatic push_field(input string tag, input string val);
		fix_field_pkg::tag_num_t num;
		logic [VALUE_BYTES*8-1:0] v;
		int keep;
		num = '0;
		v = '0;
		keep = (val.len() > VALUE_BYTES) ? VALUE_BYTES : val.len();
		for (int i = 0; i < tag.len(); i++) begin
			num = fix_field_pkg::tag_num_t'(num * 10 + (tag[i] - fix_proto_pkg::DIGIT_LO));
		end
		for (int i = 0; i < keep; i++) begin
			v[8*(VALUE_BYTES-1-i) +: 8] = val[i];
		end
		push_raw(tag);
		byte_q.push_back(fix_proto_pkg::SEP_BYTE);
		push_raw(val);
		byte_q.push_back(fix_proto_pkg::SOH_BYTE);
		exp_tag[wr_ptr] = num;
		exp_val[wr_ptr] = v;
		exp_len[wr_ptr] = fix_field_pkg::val_len_t'(keep);
		exp_ovf[wr_ptr] = (val.len() > VALUE_BYTES);
		wr_ptr++;
	endtask

	task automatic push_random_field();
		int ndig;
		int lo;
		int vlen;
		string val;
		ndig = 1 + $unsigned($random(seed)) % 5;
		lo = 1;
		for (int i = 1; i < ndig; i++) begin
			lo = lo * 10;
		end
		vlen = 1 + $unsigned($random(seed)) % VALUE_BYTES;
		val = "";
		for (int i = 0; i < vlen; i++) begin
			val = $sformatf("%s%c", val, 8'h41 + $unsigned($random(seed)) % 26);
		end
		push_field($sformatf("%0d", lo + $unsigned($random(seed)) % (9 * lo)), val);
	endtask

	// Packs the byte queue into words, earliest byte in bits 31:24.
	task automatic send_stream(input logic [7:0] pad, input int max_gap);
		int n;
		int gap;
		while (byte_q.size() % 4 != 0) begin
			byte_q.push_back(pad);
		end
		n = byte_q.size() / 4;
		wd_limit += 200 * n;
		for (int i = 0; i < n; i++) begin
			@(negedge clk_i);
			word_valid_i = 1'b1;
			word_i = {byte_q[4*i], byte_q[4*i+1], byte_q[4*i+2], byte_q[4*i+3]};
			gap = (max_gap > 0) ? $unsigned($random(seed)) % (max_gap + 1) : 0;
			repeat (gap) begin
				@(negedge clk_i);
				word_valid_i = 1'b0;
			end
		end
		@(negedge clk_i);
		word_valid_i = 1'b0;
		byte_q.delete();
	endtask

	task automatic apply_reset();
		@(negedge clk_i);
		reset_i = 1'b1;
		word_valid_i = 1'b0;
		repeat (8) @(negedge clk_i);
		reset_i = 1'b0;
	endtask

	task automatic drain();
		wait (rd_ptr == wr_ptr);
		repeat (4) @(negedge clk_i);
	endtask

	task automatic start_case(input string name);
		case_name = name;
		case_err0 = err_cnt;
		case_cnt++;
		apply_reset();
	endtask

	task automatic end_case();
		drain();
		if (err_cnt == case_err0) begin
			$display("[case %0d] %s: ok", case_cnt, case_name);
		end else begin
			case_fail++;
			$display("[case %0d] %s: %0d error(s)", case_cnt, case_name, err_cnt - case_err0);
		end
	endtask

	initial begin
		reset_i = 1'b1;
		word_valid_i = 1'b0;
		word_i = '0;

		start_case("single short field");
		push_field("35", "A");
		send_stream(fix_proto_pkg::DIGIT_LO, 0);
		end_case();

		// SOH lands at byte positions 2, 3, 0, 1, 0, 3 and '=' at 1, 3, 1, 0, 2, 2.
		start_case("delimiters at every byte position");
		push_field("49", "SENDERCOMP");
		push_field("10", "128");
		push_field("8", "FIXT");
		push_field("123", "XY");
		push_field("56", "Q");
		push_field("7", "ABCDEF");
		send_stream(fix_proto_pkg::DIGIT_LO, 0);
		end_case();

		start_case("random fields with idle gaps");
		repeat (20) push_random_field();
		send_stream(fix_proto_pkg::DIGIT_LO, 3);
		end_case();

		start_case("value overflow");
		push_field("58", "THIRTEENBYTES");
		push_field("11", "OK");
		send_stream(fix_proto_pkg::DIGIT_LO, 0);
		end_case();

		start_case("reset inside a field");
		push_field("35", "D");
		push_field("49", "BANK");
		push_raw("56=PARTIAL"); // Never terminated.
		send_stream("Z", 0);
		drain();
		apply_reset();
		push_field("34", "17");
		push_field("52", "NEWSTART");
		send_stream(fix_proto_pkg::DIGIT_LO, 0);
		end_case();

		$display("cases run %0d, ok %0d, failing %0d, errors %0d",
			case_cnt, case_cnt - case_fail, case_fail, err_cnt);
		if (case_fail == 0 && err_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		while (wd_cycles <= wd_limit) begin
			@(posedge clk_i);
			wd_cycles++;
		end
		$display("timeout after %0d cycles: %0d expected fields never arrived",
			wd_cycles, wr_ptr - rd_ptr);
		$display("test failed");
		$finish;
	end

endmodule

// File: sources.f
fix_proto_pkg.sv
fix_field_pkg.sv
fix_delim_decode.sv
fix_field_split.sv
fix_field_assemble.sv
fix_parser_top.sv
tb_fix_parser.sv

// File: Bender.yml
package:
  name: fix_parser

sources:
  - fix_proto_pkg.sv
  - fix_field_pkg.sv
  - fix_delim_decode.sv
  - fix_field_split.sv
  - fix_field_assemble.sv
  - fix_parser_top.sv
  - target: simulation
    files:
      - tb_fix_parser.sv
